//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mat_idu_decd
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- mat_dispatch_pkg.sv
`default_nettype none

package mat_dispatch_pkg;

    import mat_isa_pkg::*;

    typedef struct packed {
        mat_alu_op_e op;
        logic        dstm_vld;
        logic [2:0]  dstm_idx;
        logic        src0m_vld;
        logic        src0m_unsigned; // int widening
        logic [2:0]  src0m_idx;
        logic        src1m_vld;
        logic        src1m_unsigned;
        logic [2:0]  src1m_idx;
        logic        src0_vld;       // gpr operand
        logic [4:0]  src0_reg;
        logic        uimm3_vld;
        logic [2:0]  uimm3;
        logic [1:0]  elm_width;      // 8/16/32/64
    } mat_alu_data_t;

    typedef struct packed {
        mat_lsu_op_e op;
        logic        dstm_vld;       // load target
        logic [2:0]  dstm_idx;
        logic        src2m_vld;      // store source
        logic [2:0]  src2m_idx;
        logic        src0_vld;
        logic [4:0]  src0_reg;
        logic        src1_vld;
        logic [4:0]  src1_reg;
        logic        nf_vld;         // whole register form
        logic [2:0]  nf;
        logic [1:0]  elm_width;
    } mat_lsu_data_t;

    typedef struct packed {
        mat_cfg_op_e op;
        logic        dst_x0;
        logic        dst_vld;
        logic [4:0]  dst_reg;
        logic        src0_vld;
        logic [4:0]  src0_reg;
        logic        uimm7_vld;      // immediate instead of gpr
        logic [6:0]  uimm7;
    } mat_cfg_data_t;

endpackage

`default_nettype wire

//--- mat_idu_alu_decd.sv
`timescale 1ns/1ps
`default_nettype none

module mat_idu_alu_decd
    import mat_isa_pkg::*, mat_dispatch_pkg::*;
(
    mat_inst_if.consumer  inst,
    output logic          alu_vld,
    output mat_alu_data_t alu_data
);

    mat_alu_op_e op;
    logic        arith_form;
    logic        dstm_vld;
    logic        srcm0_vld;
    logic        srcm1_vld;
    logic        uimm3_vld;
    logic        srcm0_unsigned;
    logic        srcm1_unsigned;
    logic [2:0]  uimm3;

    assign arith_form = !inst.key.size && (inst.key.uop <= 3'd3); // mm, mv.x, mv.i, mx
    assign uimm3      = inst.inst[9:7];

    always_comb
    begin
        op = MAT_ALU_NONE;
        if (inst.inst_class == MAT_CAL)
        begin
            case (inst.key.func)
                4'd0:
                    if (!inst.key.size && inst.key.uop <= 3'd2)
                        op = MAT_ALU_MMOV;
                4'd1:
                    if (inst.key.uop == 3'd0)
                    begin
                        if (inst.key.size)
                            op = MAT_ALU_FWMMACC;
                        else
                            op = MAT_ALU_FMMACC;
                    end
                4'd2:
                    if (!inst.key.size && inst.key.uop == 3'd0)
                        op = MAT_ALU_MMAQA;
                4'd3:
                    if (arith_form)
                        op = MAT_ALU_MADD;
                4'd4:
                    if (arith_form)
                        op = MAT_ALU_MSUB;
                4'd5:
                    if (arith_form)
                        op = MAT_ALU_MSRA;
                4'd6:
                    if (arith_form)
                        op = MAT_ALU_MN4CLIP;
                4'd7:
                    if (arith_form)
                        op = MAT_ALU_MN4CLIPU;
                4'd8:
                    if (arith_form)
                        op = MAT_ALU_MMUL;
                4'd9:
                    if (arith_form)
                        op = MAT_ALU_MMULH;
                default:
                    op = MAT_ALU_NONE;
            endcase
        end
    end

    // operand form follows from uop once the op is known
    assign dstm_vld  = (op != MAT_ALU_NONE);
    assign srcm0_vld = dstm_vld && (inst.key.uop != 3'd3);  // mx takes gpr only
    assign srcm1_vld = dstm_vld && (inst.key.func != 4'd0); // mmov has one source
    assign uimm3_vld = dstm_vld && (inst.key.uop == 3'd2);

    // only meaningful for mmaqa
    always_comb
    begin
        case (uimm3)
            3'b001:
            begin
                srcm0_unsigned = 1'b1;
                srcm1_unsigned = 1'b1;
            end
            3'b010:
            begin
                srcm0_unsigned = 1'b1;
                srcm1_unsigned = 1'b0;
            end
            3'b011:
            begin
                srcm0_unsigned = 1'b0;
                srcm1_unsigned = 1'b1;
            end
            default:
            begin
                srcm0_unsigned = 1'b0;
                srcm1_unsigned = 1'b0;
            end
        endcase
    end

    assign alu_vld  = inst.vld && dstm_vld;
    assign alu_data = '{
        op:             op,
        dstm_vld:       dstm_vld,
        dstm_idx:       inst.inst[17:15],
        src0m_vld:      srcm0_vld,
        src0m_unsigned: srcm0_unsigned,
        src0m_idx:      inst.inst[20:18],
        src1m_vld:      srcm1_vld,
        src1m_unsigned: srcm1_unsigned,
        src1m_idx:      inst.inst[23:21],
        src0_vld:       inst.src0_vld,
        src0_reg:       inst.src0_reg,
        uimm3_vld:      uimm3_vld,
        uimm3:          uimm3,
        elm_width:      inst.inst[11:10]
    };

    a_op_onehot : assert property (@(posedge inst.cpuclk)
        alu_vld |-> $onehot(alu_data.op));

endmodule

`default_nettype wire

//--- mat_idu_cfg_decd.sv
`timescale 1ns/1ps
`default_nettype none

module mat_idu_cfg_decd
    import mat_isa_pkg::*, mat_dispatch_pkg::*;
(
    mat_inst_if.consumer  inst,
    output logic          cfg_vld,
    output mat_cfg_data_t cfg_data
);

    mat_cfg_op_e op;
    logic        uimm7_vld;

    always_comb
    begin
        op = MAT_CFG_NONE;
        if (inst.inst_class == MAT_CFG && inst.key.uop == 3'd7)
        begin
            case (inst.key.func[2:0])
                3'b000: op = MAT_CFG_K;   // func bit 3 ignored
                3'b001: op = MAT_CFG_M;
                3'b010: op = MAT_CFG_N;
                3'b111:
                    if (inst.key.func[3] && !inst.key.size)
                        op = MAT_CFG_ALL; // all three sizes from gprs
                default: op = MAT_CFG_NONE;
            endcase
        end
    end

    // immediate form when no gpr source
    assign uimm7_vld = (op inside {MAT_CFG_K, MAT_CFG_M, MAT_CFG_N}) && !inst.src0_vld;

    assign cfg_vld  = inst.vld && (op != MAT_CFG_NONE);
    assign cfg_data = '{
        op:        op,
        dst_x0:    inst.dst_x0,
        dst_vld:   inst.dst_vld,
        dst_reg:   inst.dst_reg,
        src0_vld:  inst.src0_vld,
        src0_reg:  inst.src0_reg,
        uimm7_vld: uimm7_vld,
        uimm7:     inst.inst[24:18]
    };

endmodule

`default_nettype wire

//--- mat_idu_decd_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mat_idu_macros.svh"

module mat_idu_decd_top
    import mat_dispatch_pkg::*;
(
    input  logic                           cpuclk,
    input  logic                           reset,
    input  logic                           inst_vld,
    input  logic [`MAT_M_DATA_WIDTH-1:0]   inst_m_data,
    output logic                           alu_vld,
    output logic [`MAT_ALU_DATA_WIDTH-1:0] alu_data,
    output logic                           lsu_vld,
    output logic [`MAT_LSU_DATA_WIDTH-1:0] lsu_data,
    output logic                           cfg_vld,
    output logic [`MAT_CFG_DATA_WIDTH-1:0] cfg_data
);

    mat_alu_data_t alu_payload;
    mat_lsu_data_t lsu_payload;
    mat_cfg_data_t cfg_payload;

    mat_inst_if i_inst_if (.cpuclk(cpuclk));

    mat_idu_inst_reg i_mat_idu_inst_reg (
        .cpuclk      (cpuclk),
        .reset       (reset),
        .inst_vld    (inst_vld),
        .inst_m_data (inst_m_data),
        .inst        (i_inst_if.producer)
    );

    mat_idu_alu_decd i_mat_idu_alu_decd (
        .inst     (i_inst_if.consumer),
        .alu_vld  (alu_vld),
        .alu_data (alu_payload)
    );

    mat_idu_lsu_decd i_mat_idu_lsu_decd (
        .inst     (i_inst_if.consumer),
        .lsu_vld  (lsu_vld),
        .lsu_data (lsu_payload)
    );

    mat_idu_cfg_decd i_mat_idu_cfg_decd (
        .inst     (i_inst_if.consumer),
        .cfg_vld  (cfg_vld),
        .cfg_data (cfg_payload)
    );

    assign alu_data = alu_payload; // flat payload vectors
    assign lsu_data = lsu_payload;
    assign cfg_data = cfg_payload;

endmodule

`default_nettype wire

//--- mat_idu_inst_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "mat_idu_macros.svh"

module mat_idu_inst_reg
    import mat_isa_pkg::*;
(
    input  logic                         cpuclk,
    input  logic                         reset,
    input  logic                         inst_vld,
    input  logic [`MAT_M_DATA_WIDTH-1:0] inst_m_data,
    mat_inst_if.producer                 inst
);

    logic                         vld_q;
    logic [`MAT_M_DATA_WIDTH-1:0] data_q;

    always_ff @(posedge cpuclk)
    begin
        if (reset)
            vld_q <= 1'b0;
        else
            vld_q <= inst_vld;
    end

    always_ff @(posedge cpuclk)
    begin
        if (inst_vld)
            data_q <= inst_m_data; // hold last word when idle
    end

    assign inst.vld        = vld_q;
    assign inst.inst_class = mat_class_e'(data_q[`MAT_M_TYPE_MSB:`MAT_M_TYPE_LSB]);
    assign inst.inst       = data_q[`MAT_M_INST_MSB:`MAT_M_INST_LSB];
    assign inst.key        = mat_decd_key_t'(data_q[`MAT_M_INST_MSB -: $bits(mat_decd_key_t)]);
    assign inst.dst_x0     = data_q[`MAT_M_DST_X0];
    assign inst.dst_vld    = data_q[`MAT_M_DST_VLD];
    assign inst.dst_reg    = data_q[`MAT_M_DST_REG_MSB:`MAT_M_DST_REG_LSB];
    assign inst.src0_vld   = data_q[`MAT_M_SRC0_VLD];
    assign inst.src0_reg   = data_q[`MAT_M_SRC0_REG_MSB:`MAT_M_SRC0_REG_LSB];
    assign inst.src1_vld   = data_q[`MAT_M_SRC1_VLD];
    assign inst.src1_reg   = data_q[`MAT_M_SRC1_REG_MSB:`MAT_M_SRC1_REG_LSB];

    // a registered valid word carries at most one class bit
    a_class_onehot : assert property (@(posedge cpuclk) disable iff (reset)
        inst.vld |-> $onehot0(inst.inst_class));

endmodule

`default_nettype wire

//--- mat_idu_lsu_decd.sv
`timescale 1ns/1ps
`default_nettype none

module mat_idu_lsu_decd
    import mat_isa_pkg::*, mat_dispatch_pkg::*;
(
    mat_inst_if.consumer  inst,
    output logic          lsu_vld,
    output mat_lsu_data_t lsu_data
);

    mat_lsu_op_e op;
    logic        nf_vld;

    always_comb
    begin
        op     = MAT_LSU_NONE;
        nf_vld = 1'b0;
        if (inst.inst_class == MAT_LSU && inst.key.uop inside {3'd4, 3'd5})
        begin
            // func 0 single form any size, func 2 whole register form size 0
            if (inst.key.func == 4'd0 || (inst.key.func == 4'd2 && !inst.key.size))
            begin
                if (inst.key.uop[0])
                    op = MAT_LSU_STORE;
                else
                    op = MAT_LSU_LOAD;
                nf_vld = inst.key.func[1]; // register count from nf
            end
        end
    end

    assign lsu_vld  = inst.vld && (op != MAT_LSU_NONE);
    assign lsu_data = '{
        op:        op,
        dstm_vld:  (op == MAT_LSU_LOAD),
        dstm_idx:  inst.inst[9:7],
        src2m_vld: (op == MAT_LSU_STORE),
        src2m_idx: inst.inst[9:7],  // shares bits with dstm
        src0_vld:  inst.src0_vld,
        src0_reg:  inst.src0_reg,
        src1_vld:  inst.src1_vld,
        src1_reg:  inst.src1_reg,
        nf_vld:    nf_vld,
        nf:        inst.inst[22:20],
        elm_width: inst.inst[11:10]
    };

endmodule

`default_nettype wire

//--- mat_idu_macros.svh
`ifndef MAT_IDU_MACROS_SVH
`define MAT_IDU_MACROS_SVH

// pre-decoded matrix instruction word
`define MAT_M_DATA_WIDTH   55
`define MAT_M_INST_MSB     54 // 32-bit instruction
`define MAT_M_INST_LSB     23
`define MAT_M_TYPE_MSB     22 // one-hot instruction class
`define MAT_M_TYPE_LSB     19
`define MAT_M_DST_X0       18
`define MAT_M_DST_VLD      17
`define MAT_M_DST_REG_MSB  16
`define MAT_M_DST_REG_LSB  12
`define MAT_M_SRC0_VLD     11
`define MAT_M_SRC0_REG_MSB 10
`define MAT_M_SRC0_REG_LSB 6
`define MAT_M_SRC1_VLD     5
`define MAT_M_SRC1_REG_MSB 4
`define MAT_M_SRC1_REG_LSB 0

// dispatch payloads
`define MAT_ALU_DATA_WIDTH 37
`define MAT_LSU_DATA_WIDTH 28
`define MAT_CFG_DATA_WIDTH 25

`endif

//--- mat_inst_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mat_inst_if
    import mat_isa_pkg::*;
(
    input logic cpuclk
);

    logic          vld;
    mat_class_e    inst_class;
    mat_decd_key_t key;        // func, uop, size
    logic [31:0]   inst;
    logic          dst_x0;
    logic          dst_vld;
    logic [4:0]    dst_reg;
    logic          src0_vld;
    logic [4:0]    src0_reg;
    logic          src1_vld;
    logic [4:0]    src1_reg;

    modport producer (output vld, inst_class, key, inst, dst_x0, dst_vld, dst_reg,
                      src0_vld, src0_reg, src1_vld, src1_reg);

    modport consumer (input cpuclk, vld, inst_class, key, inst, dst_x0, dst_vld, dst_reg,
                      src0_vld, src0_reg, src1_vld, src1_reg);

endinterface

`default_nettype wire

//--- mat_isa_pkg.sv
`default_nettype none

package mat_isa_pkg;

    typedef enum logic [3:0] {
        MAT_CAL         = 4'b0001,
        MAT_LSU         = 4'b0010,
        MAT_CFG         = 4'b0100,
        MAT_SPECIAL_MOV = 4'b1000  // defined by the isa but not decoded here
    } mat_class_e;

    typedef enum logic [10:0] {
        MAT_ALU_NONE     = 11'b000_0000_0000,
        MAT_ALU_MMOV     = 11'b000_0000_0001,
        MAT_ALU_FMMACC   = 11'b000_0000_0010,
        MAT_ALU_FWMMACC  = 11'b000_0000_0100, // widening to dest
        MAT_ALU_MMAQA    = 11'b000_0000_1000,
        MAT_ALU_MADD     = 11'b000_0001_0000,
        MAT_ALU_MSUB     = 11'b000_0010_0000,
        MAT_ALU_MSRA     = 11'b000_0100_0000,
        MAT_ALU_MN4CLIP  = 11'b000_1000_0000, // signed clip
        MAT_ALU_MN4CLIPU = 11'b001_0000_0000, // unsigned clip
        MAT_ALU_MMUL     = 11'b010_0000_0000,
        MAT_ALU_MMULH    = 11'b100_0000_0000
    } mat_alu_op_e;

    typedef enum logic [1:0] {
        MAT_LSU_NONE  = 2'b00,
        MAT_LSU_LOAD  = 2'b01,
        MAT_LSU_STORE = 2'b10
    } mat_lsu_op_e;

    typedef enum logic [3:0] {
        MAT_CFG_NONE = 4'b0000,
        MAT_CFG_K    = 4'b0001,
        MAT_CFG_M    = 4'b0010,
        MAT_CFG_N    = 4'b0100,
        MAT_CFG_ALL  = 4'b1000
    } mat_cfg_op_e;

    // instruction bits 31:24
    typedef struct packed {
        logic [3:0] func;
        logic [2:0] uop;
        logic       size;
    } mat_decd_key_t;

endpackage

`default_nettype wire

//--- src.f
+incdir+.
mat_isa_pkg.sv
mat_dispatch_pkg.sv
mat_inst_if.sv
mat_idu_inst_reg.sv
mat_idu_alu_decd.sv
mat_idu_lsu_decd.sv
mat_idu_cfg_decd.sv
mat_idu_decd_top.sv
tb_mat_idu_decd.sv

//--- tb_mat_idu_decd.sv
`timescale 1ns/1ps
`default_nettype none

`include "mat_idu_macros.svh"

module tb_mat_idu_decd;

    localparam int DRAIN_LIMIT = 20; // cycles to wait for the last word

    typedef struct packed {
        logic                           alu_vld;
        logic [`MAT_ALU_DATA_WIDTH-1:0] alu_data;
        logic                           lsu_vld;
        logic [`MAT_LSU_DATA_WIDTH-1:0] lsu_data;
        logic                           cfg_vld;
        logic [`MAT_CFG_DATA_WIDTH-1:0] cfg_data;
    } expect_t;

    logic                           cpuclk;
    logic                           reset;
    logic                           inst_vld;
    logic [`MAT_M_DATA_WIDTH-1:0]   inst_m_data;
    logic                           alu_vld;
    logic [`MAT_ALU_DATA_WIDTH-1:0] alu_data;
    logic                           lsu_vld;
    logic [`MAT_LSU_DATA_WIDTH-1:0] lsu_data;
    logic                           cfg_vld;
    logic [`MAT_CFG_DATA_WIDTH-1:0] cfg_data;

    integer  seed;
    int      check_count;
    int      error_count;
    int      test_checks;
    int      test_errors;
    int      sent_words;
    int      checked_words;
    expect_t expected;
    logic    had_word;

    mat_idu_decd_top i_mat_idu_decd_top (
        .cpuclk      (cpuclk),
        .reset       (reset),
        .inst_vld    (inst_vld),
        .inst_m_data (inst_m_data),
        .alu_vld     (alu_vld),
        .alu_data    (alu_data),
        .lsu_vld     (lsu_vld),
        .lsu_data    (lsu_data),
        .cfg_vld     (cfg_vld),
        .cfg_data    (cfg_data)
    );

    always #50 cpuclk = ~cpuclk; // 100 ns period

    // expected dispatch for one registered word
    function automatic expect_t mat_decd_ref(input logic vld, input logic [54:0] w);
        logic [31:0] in;
        logic [3:0]  cls;
        logic [3:0]  func;
        logic [2:0]  uop;
        logic        sz;
        logic [10:0] aop;
        logic [1:0]  lop;
        logic [3:0]  cop;
        logic [2:0]  u3;
        logic        nfv;
        logic        any_a;
        expect_t     e;
        in   = w[54:23];
        cls  = w[22:19];
        func = in[31:28];
        uop  = in[27:25];
        sz   = in[24];
        u3   = in[9:7];
        aop  = 11'd0;
        if (cls == 4'b0001)
        begin
            if (func == 4'd0 && !sz && uop <= 3'd2)
                aop = 11'd1; // mmov
            else if (func == 4'd1 && uop == 3'd0)
                aop = sz ? 11'b100 : 11'b010;
            else if (func == 4'd2 && uop == 3'd0 && !sz)
                aop = 11'b1000; // mmaqa
            else if (func >= 4'd3 && func <= 4'd9 && uop <= 3'd3 && !sz)
                aop = 11'd1 << (func + 4'd1); // madd .. mmulh
        end
        any_a = (aop != 11'd0);
        e.alu_vld  = vld && any_a;
        e.alu_data = {aop, any_a, in[17:15], any_a && (uop != 3'd3),
                      (u3 == 3'd1) || (u3 == 3'd2), in[20:18],
                      any_a && (func != 4'd0), (u3 == 3'd1) || (u3 == 3'd3), in[23:21],
                      w[11], w[10:6], any_a && (uop == 3'd2), u3, in[11:10]};
        lop = 2'b00;
        nfv = 1'b0;
        if (cls == 4'b0010 && (uop == 3'd4 || uop == 3'd5)
            && (func == 4'd0 || (func == 4'd2 && !sz)))
        begin
            lop = (uop == 3'd5) ? 2'b10 : 2'b01;
            nfv = (func == 4'd2); // whole register form
        end
        e.lsu_vld  = vld && (lop != 2'b00);
        e.lsu_data = {lop, lop == 2'b01, in[9:7], lop == 2'b10, in[9:7], w[11], w[10:6],
                      w[5], w[4:0], nfv, in[22:20], in[11:10]};
        cop = 4'b0000;
        if (cls == 4'b0100 && uop == 3'd7)
        begin
            if (func[2:0] == 3'd0)
                cop = 4'b0001;
            else if (func[2:0] == 3'd1)
                cop = 4'b0010;
            else if (func[2:0] == 3'd2)
                cop = 4'b0100;
            else if (func == 4'hf && !sz)
                cop = 4'b1000;
        end
        e.cfg_vld  = vld && (cop != 4'b0000);
        e.cfg_data = {cop, w[18], w[17], w[16:12], w[11], w[10:6],
                      (cop[2:0] != 3'd0) && !w[11], in[24:18]};
        return e;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] want);
        check_count++;
        if (got !== want)
        begin
            error_count++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    // latch the reference at the sampling edge and compare on the falling edge
    always
    begin
        @(posedge cpuclk);
        had_word = inst_vld && !reset;
        expected = mat_decd_ref(had_word, inst_m_data);
        @(negedge cpuclk);
        check_value("alu_vld", 64'(alu_vld), 64'(expected.alu_vld));
        check_value("lsu_vld", 64'(lsu_vld), 64'(expected.lsu_vld));
        check_value("cfg_vld", 64'(cfg_vld), 64'(expected.cfg_vld));
        if (expected.alu_vld)
            check_value("alu_data", 64'(alu_data), 64'(expected.alu_data));
        if (expected.lsu_vld)
            check_value("lsu_data", 64'(lsu_data), 64'(expected.lsu_data));
        if (expected.cfg_vld)
            check_value("cfg_data", 64'(cfg_data), 64'(expected.cfg_data));
        if (had_word)
            checked_words++;
    end

    // random word with zero or one class bit
    task automatic rand_word(output logic [`MAT_M_DATA_WIDTH-1:0] w);
        logic [31:0] r0;
        logic [31:0] r1;
        logic [31:0] r2;
        r0 = $random(seed);
        r1 = $random(seed);
        r2 = $random(seed);
        w = {r0, 4'b0000, r1[18:0]};
        w[22:19] = (r2[4:2] == 3'd0) ? 4'b0000 : (4'b0001 << r2[1:0]);
    endtask

    task automatic drive_word(input logic [`MAT_M_DATA_WIDTH-1:0] w);
        @(negedge cpuclk);
        inst_vld    = 1'b1;
        inst_m_data = w;
        sent_words++;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(negedge cpuclk);
            inst_vld = 1'b0;
        end
    endtask

    task automatic start_test();
        test_checks = check_count;
        test_errors = error_count;
    endtask

    task automatic finish_test(input string name);
        int waited;
        idle_cycles(1);
        waited = 0;
        while (checked_words != sent_words)
        begin
            if (waited >= DRAIN_LIMIT)
            begin
                $display("timeout: %0d words driven but only %0d checked in test %s",
                         sent_words, checked_words, name);
                $display("Simulation finished: FAIL");
                $finish;
            end
            @(negedge cpuclk);
            waited++;
        end
        idle_cycles(1);
        $display("test %s: %0d checks, %0d errors", name,
                 check_count - test_checks, error_count - test_errors);
    endtask

    initial
    begin
        logic [`MAT_M_DATA_WIDTH-1:0] w;
        seed          = 32'h3b74_fe40;
        cpuclk        = 1'b0;
        reset         = 1'b1;
        inst_vld      = 1'b1; // mmov word offered during reset must not dispatch
        inst_m_data   = {8'h00, 24'h00_0000, 4'b0001, 19'h0_0000};
        check_count   = 0;
        error_count   = 0;
        sent_words    = 0;
        checked_words = 0;
        repeat (5) @(negedge cpuclk);
        reset    = 1'b0;
        inst_vld = 1'b0;

        start_test();
        idle_cycles(6); // valids stay low with no strobe
        finish_test("reset_idle");

        start_test();
        for (int k = 0; k < 256; k++)
        begin
            rand_word(w);
            w[54:47] = 8'(k); // func, uop, size
            w[22:19] = 4'b0001;
            drive_word(w);
        end
        for (int u = 0; u < 8; u++)
        begin
            rand_word(w);
            w[54:47] = {4'd2, 3'd0, 1'b0};
            w[22:19] = 4'b0001;
            w[32:30] = 3'(u); // uimm3 picks mmaqa signedness
            drive_word(w);
        end
        finish_test("alu_table");

        start_test();
        for (int k = 0; k < 16; k++)
        begin
            rand_word(w);
            w[54:51] = k[1] ? 4'd2 : 4'd0;
            w[50:48] = k[0] ? 3'd5 : 3'd4;
            if (k[1])
                w[47] = 1'b0;
            w[22:19] = 4'b0010;
            drive_word(w);
        end
        finish_test("lsu_forms");

        start_test();
        for (int k = 0; k < 12; k++)
        begin
            rand_word(w);
            w[54:51] = {k[3], 3'(k % 3)};
            w[50:48] = 3'd7;
            w[11]    = k[2];
            w[22:19] = 4'b0100;
            drive_word(w);
        end
        for (int k = 0; k < 4; k++)
        begin
            rand_word(w);
            w[54:47] = {4'hf, 3'd7, 1'b0};
            w[22:19] = 4'b0100;
            drive_word(w);
        end
        finish_test("cfg_forms");

        start_test();
        for (int k = 0; k < 24; k++)
        begin
            rand_word(w);
            w[22:19] = k[0] ? 4'b1000 : 4'b0000; // special move or no class
            drive_word(w);
        end
        for (int k = 0; k < 200; k++)
        begin
            rand_word(w);
            drive_word(w);
        end
        finish_test("no_match_and_random");

        $display("total: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
